// ==== project.f ====
+incdir+verilog
verilog/bridge_pkg.sv
verilog/gray_counter.sv
verilog/dual_clock_ram.sv
verilog/async_fifo.sv
verilog/credit_ingress.sv
verilog/credit_egress.sv
verilog/cdc_bridge.sv
bench/tb_cdc_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build the cdc bridge testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f \
   --top-module tb_cdc_bridge -o sim_cdc_bridge || exit 1

out=$(./obj_dir/sim_cdc_bridge)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "Everything OK" && echo "run passed" || { echo "run failed"; exit 1; }

exit 0

// ==== bench/tb_cdc_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module tb_cdc_bridge
   import bridge_pkg::*;
();

   localparam int N_TRAFFIC = 400;

   logic  wclk;
   logic  rclk;
   logic  rst;
   logic  in_valid;
   flit_t in_flit;
   logic  crd_return;
   logic  overflow;
   logic  crd_grant;
   logic  out_valid;
   flit_t out_flit;

   integer seed;
   integer w_seed;
   integer r_seed;
   int     mismatch_errors;
   int     other_errors;
   int     up_credits;
   int     dn_credits;
   int     spare_credits;
   int     sent_count;
   int     recv_count;
   int     bp_start;
   int     cycles;
   bit     send_en;
   bit     grant_en;
   bit     hold_return;
   bit     extra_req;
   bit     extra_sent;
   flit_t  sent_q[$];

   cdc_bridge i_cdc_bridge (
      .wclk       (wclk),
      .rclk       (rclk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .crd_return (crd_return),
      .overflow   (overflow),
      .crd_grant  (crd_grant),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

   always #50 wclk = ~wclk;
   always #35 rclk = ~rclk;

   task automatic flag_mismatch(input string msg);
      mismatch_errors++;
      $display("mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      other_errors++;
      $display("failure at %0t ns: %s", $time, msg);
   endtask

   function automatic flit_t random_flit();
      integer rnd;
      flit_t  f;
      rnd = $random(w_seed);
      f.payload = rnd[`BRIDGE_DATA_W-1:0];
      f.last = rnd[`BRIDGE_DATA_W];
      return f;
   endfunction

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures, %0d flits checked",
               mismatch_errors, other_errors, recv_count);
      if (mismatch_errors + other_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   endtask

   // upstream model, wclk domain
   always @(negedge wclk) begin
      flit_t f;
      integer rnd;
      if (crd_return) begin
         if (hold_return) begin
            note_failure("credit returned while no flit could have left the fifo");
         end
         up_credits = up_credits + 1;
         if (up_credits > `BRIDGE_DEPTH) begin
            note_failure("upstream credits rose above the fifo depth");
         end
         // returned credits can never outrun flits seen at the output
         if (up_credits + sent_count - `BRIDGE_DEPTH > recv_count) begin
            note_failure("credit returned before its flit left the bridge");
         end
      end
      if (overflow && !extra_sent) begin
         flag_mismatch("overflow set although every send held a credit");
      end
      in_valid <= 1'b0;
      rnd = $random(w_seed);
      if (extra_req) begin
         // deliberate send without a credit, must be dropped
         f = random_flit();
         in_valid <= 1'b1;
         in_flit <= f;
         extra_req = 1'b0;
         extra_sent = 1'b1;
      end else if (send_en && up_credits > 0 && rnd[0]) begin
         f = random_flit();
         in_valid <= 1'b1;
         in_flit <= f;
         sent_q.push_back(f);
         sent_count++;
         up_credits = up_credits - 1;
      end
   end

   // downstream model and scoreboard, rclk domain
   always @(negedge rclk) begin
      flit_t  exp_flit;
      integer rnd;
      if (out_valid) begin
         if (dn_credits == 0) begin
            note_failure("out_valid fired while no downstream credit was held");
         end else begin
            dn_credits = dn_credits - 1;
         end
         if (sent_q.size() == 0) begin
            note_failure("out_valid fired with no flit outstanding");
         end else begin
            exp_flit = sent_q.pop_front();
            recv_count++;
            if (out_flit !== exp_flit) begin
               flag_mismatch($sformatf("flit %0d: expected %h/%b, got %h/%b",
                  recv_count, exp_flit.payload, exp_flit.last,
                  out_flit.payload, out_flit.last));
            end
         end
      end
      crd_grant <= 1'b0;
      rnd = $random(r_seed);
      // grant for flits still owed plus any spare credits
      if (grant_en && dn_credits < sent_q.size() + spare_credits && rnd[1:0] != 2'b00) begin
         crd_grant <= 1'b1;
         dn_credits = dn_credits + 1;
      end
   end

   initial begin
      seed = 32'hecfdb8f7;
      // one stream per clock domain
      w_seed = $random(seed);
      r_seed = $random(seed);
      wclk = 1'b0;
      rclk = 1'b0;
      rst = 1'b1;
      in_valid = 1'b0;
      in_flit = '0;
      crd_grant = 1'b0;
      mismatch_errors = 0;
      other_errors = 0;
      up_credits = `BRIDGE_DEPTH;
      dn_credits = 0;
      spare_credits = 0;
      sent_count = 0;
      recv_count = 0;
      send_en = 1'b0;
      grant_en = 1'b0;
      hold_return = 1'b0;
      extra_req = 1'b0;
      extra_sent = 1'b0;
      begin : phases
         repeat (10) @(posedge wclk);
         @(negedge wclk);
         rst = 1'b0;

         // quiet outputs after reset
         repeat (8) begin
            @(negedge wclk);
            if (crd_return !== 1'b0 || overflow !== 1'b0) begin
               flag_mismatch("crd_return or overflow high after reset");
            end
            @(negedge rclk);
            if (out_valid !== 1'b0) begin
               flag_mismatch("out_valid high after reset");
            end
         end

         // random traffic in both domains
         @(posedge rclk);
         send_en = 1'b1;
         grant_en = 1'b1;
         cycles = 0;
         while (sent_count < N_TRAFFIC && cycles < 20000) begin
            @(posedge wclk);
            cycles++;
         end
         if (sent_count < N_TRAFFIC) begin
            note_failure("timeout: upstream never managed to send all traffic");
            disable phases;
         end
         send_en = 1'b0;

         cycles = 0;
         while (recv_count < sent_count && cycles < 2000) begin
            @(posedge wclk);
            cycles++;
         end
         if (recv_count < sent_count) begin
            note_failure("timeout: fifo did not drain after random traffic");
            disable phases;
         end
         cycles = 0;
         while (up_credits != `BRIDGE_DEPTH && cycles < 200) begin
            @(posedge wclk);
            cycles++;
         end
         if (up_credits != `BRIDGE_DEPTH) begin
            note_failure("timeout: upstream credits never returned to full depth");
            disable phases;
         end

         // back-pressure with downstream grants withheld
         grant_en = 1'b0;
         hold_return = 1'b1;
         bp_start = sent_count;
         send_en = 1'b1;
         cycles = 0;
         while (up_credits != 0 && cycles < 500) begin
            @(posedge wclk);
            cycles++;
         end
         if (up_credits != 0) begin
            note_failure("timeout: upstream credits never ran out under back-pressure");
            disable phases;
         end
         send_en = 1'b0;
         if (sent_count - bp_start != `BRIDGE_DEPTH) begin
            flag_mismatch($sformatf("%0d flits accepted before stall, expected %0d",
               sent_count - bp_start, `BRIDGE_DEPTH));
         end
         repeat (4) @(posedge wclk);
         @(negedge wclk);
         if (overflow !== 1'b0) begin
            flag_mismatch("overflow set while filling the fifo");
         end

         @(posedge wclk);
         extra_req = 1'b1;
         cycles = 0;
         while (overflow !== 1'b1 && cycles < 20) begin
            @(negedge wclk);
            cycles++;
         end
         if (overflow !== 1'b1) begin
            note_failure("timeout: overflow never set by the send into a full fifo");
            disable phases;
         end

         // release and drain, the dropped flit must not show up
         @(posedge rclk);
         grant_en = 1'b1;
         hold_return = 1'b0;
         cycles = 0;
         while (recv_count < sent_count && cycles < 500) begin
            @(posedge wclk);
            cycles++;
         end
         if (recv_count < sent_count) begin
            note_failure("timeout: fifo did not drain after back-pressure");
            disable phases;
         end
         cycles = 0;
         while (up_credits != `BRIDGE_DEPTH && cycles < 200) begin
            @(posedge wclk);
            cycles++;
         end
         if (up_credits != `BRIDGE_DEPTH) begin
            note_failure("timeout: credits not restored after back-pressure");
            disable phases;
         end

         // spare credits would let a dropped flit escape
         @(posedge rclk);
         spare_credits = 2;
         repeat (20) @(posedge wclk);
      end
      finish_run();
   end

endmodule

// ==== verilog/cdc_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module cdc_bridge
   import bridge_pkg::*;
(
   input  logic  wclk,
   input  logic  rclk,
   input  logic  rst,

   // upstream, wclk domain
   input  logic  in_valid,
   input  flit_t in_flit,
   output logic  crd_return,
   output logic  overflow,

   // downstream, rclk domain
   input  logic  crd_grant,
   output logic  out_valid,
   output flit_t out_flit
);

   logic                        wr_en;
   flit_t                       wr_flit;
   logic                        full;
   logic [`BRIDGE_CREDIT_W-1:0] rd_count_w;
   logic                        rd_en;
   logic                        empty;

   credit_ingress i_ingress (
      .wclk       (wclk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .full       (full),
      .rd_count_w (rd_count_w),
      .wr_en      (wr_en),
      .wr_flit    (wr_flit),
      .crd_return (crd_return),
      .overflow   (overflow)
   );

   async_fifo i_fifo (
      .wclk       (wclk),
      .rclk       (rclk),
      .rst        (rst),
      .wr_en      (wr_en),
      .wr_flit    (wr_flit),
      .full       (full),
      .rd_count_w (rd_count_w),
      .rd_en      (rd_en),
      .rd_flit    (out_flit),
      .empty      (empty)
   );

   credit_egress i_egress (
      .rclk      (rclk),
      .rst       (rst),
      .crd_grant (crd_grant),
      .empty     (empty),
      .rd_en     (rd_en),
      .out_valid (out_valid)
   );

endmodule

// ==== verilog/credit_egress.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module credit_egress (
   input  logic rclk,
   input  logic rst,

   // downstream credit pulses
   input  logic crd_grant,

   // fifo read side
   input  logic empty,
   output logic rd_en,

   // flit qualifier, aligned with the ram output register
   output logic out_valid
);

   logic [`BRIDGE_CREDIT_W-1:0] credits;

   // pop whenever a credit is held and data is there
   assign rd_en = (credits != '0) & ~empty;

   // grant and pop in the same cycle cancel out
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         credits <= '0;
      end else begin
         case ({crd_grant, rd_en})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // ram data shows up one edge after the pop
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= rd_en;
      end
   end

endmodule

// ==== verilog/credit_ingress.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module credit_ingress
   import bridge_pkg::*;
(
   input  logic                        wclk,
   input  logic                        rst,

   // upstream
   input  logic                        in_valid,
   input  flit_t                       in_flit,

   // fifo write side
   input  logic                        full,
   input  logic [`BRIDGE_CREDIT_W-1:0] rd_count_w,
   output logic                        wr_en,
   output flit_t                       wr_flit,

   // credit return and error flag
   output logic                        crd_return,
   output logic                        overflow
);

   logic [`BRIDGE_CREDIT_W-1:0] rd_count_q;
   logic [`BRIDGE_CREDIT_W-1:0] advance;
   logic [`BRIDGE_CREDIT_W-1:0] pending;

   // flits meeting a full fifo are dropped here
   assign wr_en   = in_valid & ~full;
   assign wr_flit = in_flit;

   // sticky until reset
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         overflow <= 1'b0;
      end else if (in_valid && full) begin
         overflow <= 1'b1;
      end
   end

   // slots freed since last cycle, modulo wrap of the pointer
   assign advance = rd_count_w - rd_count_q;

   // one credit back per cycle while any are owed
   assign crd_return = (pending != '0);

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rd_count_q <= '0;
         pending    <= '0;
      end else begin
         rd_count_q <= rd_count_w;
         pending    <= pending + advance - `BRIDGE_CREDIT_W'(crd_return);
      end
   end

endmodule

// ==== verilog/async_fifo.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module async_fifo
   import bridge_pkg::*;
(
   input  logic                        wclk,
   input  logic                        rclk,
   input  logic                        rst,

   // write side, wclk domain
   input  logic                        wr_en,
   input  flit_t                       wr_flit,
   output logic                        full,
   output logic [`BRIDGE_CREDIT_W-1:0] rd_count_w,

   // read side, rclk domain
   input  logic                        rd_en,
   output flit_t                       rd_flit,
   output logic                        empty
);

   localparam int PTR_W = `BRIDGE_ADDR_W + 1;

   // write domain
   logic [PTR_W-1:0] wr_gray;
   logic [PTR_W-1:0] wr_bin;
   logic [PTR_W-1:0] rd_gray_w1;
   logic [PTR_W-1:0] rd_gray_w2;
   logic [PTR_W-1:0] rd_bin_w;
   logic [PTR_W-1:0] wr_level;
   logic             wr_do;

   // read domain
   logic [PTR_W-1:0] rd_gray;
   logic [PTR_W-1:0] rd_bin;
   logic [PTR_W-1:0] wr_gray_r1;
   logic [PTR_W-1:0] wr_gray_r2;
   logic             rd_do;

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // never write into a full fifo or pop an empty one
   assign wr_do = wr_en & ~full;
   assign rd_do = rd_en & ~empty;

   gray_counter i_wr_ptr (
      .wclk (wclk),
      .rst  (rst),
      .en   (wr_do),
      .gray (wr_gray),
      .bin  (wr_bin)
   );

   gray_counter i_rd_ptr (
      .wclk (rclk),
      .rst  (rst),
      .en   (rd_do),
      .gray (rd_gray),
      .bin  (rd_bin)
   );

   // read pointer into wclk, two flops
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
      end
   end

   // write pointer into rclk, two flops
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
      end
   end

   // occupancy as seen from the write side, may lag real pops
   assign rd_bin_w   = gray2bin(rd_gray_w2);
   assign wr_level   = wr_bin - rd_bin_w;
   assign full       = (wr_level == PTR_W'(`BRIDGE_DEPTH));
   assign rd_count_w = rd_bin_w;

   // pointers equal including the wrap bit
   assign empty = (rd_gray == wr_gray_r2);

   dual_clock_ram i_ram (
      .wclk  (wclk),
      .we    (wr_do),
      .waddr (wr_bin[`BRIDGE_ADDR_W-1:0]),
      .wdata (wr_flit),
      .rclk  (rclk),
      .re    (rd_do),
      .raddr (rd_bin[`BRIDGE_ADDR_W-1:0]),
      .rdata (rd_flit)
   );

endmodule

// ==== verilog/dual_clock_ram.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module dual_clock_ram
   import bridge_pkg::*;
(
   input  logic                      wclk,
   input  logic                      we,
   input  logic [`BRIDGE_ADDR_W-1:0] waddr,
   input  flit_t                     wdata,
   input  logic                      rclk,
   input  logic                      re,
   input  logic [`BRIDGE_ADDR_W-1:0] raddr,
   output flit_t                     rdata
);

   flit_t mem [0:`BRIDGE_DEPTH-1];

   // write port, wclk domain
   always_ff @(posedge wclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // read port, registered on rclk
   // rdata holds its value between pops
   always_ff @(posedge rclk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
   end

endmodule

// ==== verilog/gray_counter.sv ====
`timescale 1ns/1ps
`include "bridge_config.svh"

module gray_counter (
   input  logic                   wclk,
   input  logic                   rst,
   input  logic                   en,
   output logic [`BRIDGE_ADDR_W:0] gray,
   output logic [`BRIDGE_ADDR_W:0] bin
);

   logic [`BRIDGE_ADDR_W:0] bin_next;

   // next value in both codings
   assign bin_next = bin + 1'b1;

   // gray code is registered so the crossing sees one bit change per step
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         bin  <= '0;
         gray <= '0;
      end else if (en) begin
         bin  <= bin_next;
         gray <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

// ==== verilog/bridge_pkg.sv ====
`include "bridge_config.svh"

package bridge_pkg;

   // one transfer unit through the bridge
   // last marks the final word of a packet
   typedef struct packed {
      logic [`BRIDGE_DATA_W-1:0] payload;
      logic                      last;
   } flit_t;

endpackage

// ==== verilog/bridge_config.svh ====
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// payload bits carried per flit
`define BRIDGE_DATA_W 16

// fifo slot address bits
`define BRIDGE_ADDR_W 4

// slots in the fifo, also the upstream credit budget at reset
`define BRIDGE_DEPTH (1 << `BRIDGE_ADDR_W)

// credit counters and pointers need one bit above the address
`define BRIDGE_CREDIT_W (`BRIDGE_ADDR_W + 1)

`endif
